//--- source/linemult_pkg.sv
// line doubler shared definitions
package linemult_pkg;

  //////////////////////////////
  // pixel and buffer geometry
  //////////////////////////////
  localparam int COLOR_W   = 7;                   // bits per colour channel
  localparam int BUF_PAGES = 4;                   // line buffer pages
  localparam int PAGE_W    = $clog2(BUF_PAGES);
  localparam int HCNT_W    = 11;                  // covers the longest line
  localparam int ADDR_W    = 9;                   // pixel address within a page

  // default active window of an input line
  localparam int DEF_ACTIVE_START = 20;
  localparam int DEF_ACTIVE_LEN   = 320;

  //////////////////////////////
  // output timing
  //////////////////////////////
  localparam int HS_WIDTH = 24;  // hsync low cycles per output line
  localparam int VS_LINES = 6;   // output lines with vsync low
  localparam int PASS_LAT = 3;   // bypass delay in cycles

  typedef enum logic [1:0] {
    ST_WAIT_FRAME,  // wait for a frame start from the writer
    ST_RD_READY,    // wait for the next input line
    ST_READING      // doubled lines running
  } rd_state_e;

  typedef enum logic [7:0] {
    REG_CTRL   = 8'h00,  // bit 0 enable, bit 1 scanline enable
    REG_SL_STR = 8'h04   // scanline strength
  } reg_addr_e;

endpackage

//--- source/linemult_cfg_apb.sv
// line doubler configuration registers
`timescale 1ns/1ns

module linemult_cfg_apb (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [7:0]  paddr_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  output logic        enable_o,
  output logic        sl_en_o,
  output logic [7:0]  sl_str_o
);

  import linemult_pkg::*;

  logic addr_ok;
  logic wr_acc;

  // address decode and read mux
  always_comb begin
    addr_ok  = 1'b1;
    prdata_o = '0;
    case (paddr_i)
      REG_CTRL:   prdata_o = {30'd0, sl_en_o, enable_o};
      REG_SL_STR: prdata_o = {24'd0, sl_str_o};
      default:    addr_ok = 1'b0;
    endcase
  end

  assign pready_o  = 1'b1;                               // no wait states
  assign pslverr_o = psel_i && penable_i && !addr_ok;
  assign wr_acc    = psel_i && penable_i && pwrite_i && addr_ok;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_o <= 1'b0;
      sl_en_o  <= 1'b0;
      sl_str_o <= 8'd0;
    end else if (wr_acc) begin
      if (paddr_i == REG_CTRL) begin
        enable_o <= pwdata_i[0];
        sl_en_o  <= pwdata_i[1];
      end else begin
        sl_str_o <= pwdata_i[7:0];
      end
    end
  end

  // master keeps the address from setup into access
  a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    psel_i && !penable_i |=> $stable(paddr_i));

endmodule

//--- source/line_writer.sv
// input line writer
`timescale 1ns/1ns

module line_writer #(
  parameter int ACTIVE_START = linemult_pkg::DEF_ACTIVE_START,
  parameter int ACTIVE_LEN   = linemult_pkg::DEF_ACTIVE_LEN
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              pix_valid_i,
  input  logic                              hsync_n_i,
  input  logic                              vsync_n_i,
  input  logic [linemult_pkg::COLOR_W-1:0]  red_i,
  input  logic [linemult_pkg::COLOR_W-1:0]  green_i,
  input  logic [linemult_pkg::COLOR_W-1:0]  blue_i,
  input  logic [linemult_pkg::PAGE_W-1:0]   rd_page_i,
  output logic                              wr_en_o,
  output logic [linemult_pkg::PAGE_W-1:0]   wr_page_o,
  output logic [linemult_pkg::ADDR_W-1:0]   wr_addr_o,
  output logic [3*linemult_pkg::COLOR_W-1:0] wr_data_o,
  output logic                              line_start_o,
  output logic                              frame_tgl_o,
  output logic                              line_ok_o,
  output logic [linemult_pkg::HCNT_W-1:0]   rd_len_o
);

  import linemult_pkg::*;

  localparam logic [HCNT_W-1:0] PCNT_MAX = '1;

  logic              hs_prev, vs_prev;
  logic              hs_fall, vs_fall;
  logic              in_win;
  logic [HCNT_W-1:0] pcnt, p_cur;
  logic [HCNT_W-1:0] len_tbl [BUF_PAGES];  // pixel count per stored line

  assign hs_fall = pix_valid_i && hs_prev && !hsync_n_i;
  assign vs_fall = pix_valid_i && vs_prev && !vsync_n_i;
  assign p_cur   = hs_fall ? '0 : (pcnt == PCNT_MAX) ? pcnt : pcnt + 1'b1;  // saturates
  assign in_win  = (p_cur >= ACTIVE_START) && (p_cur < ACTIVE_START + ACTIVE_LEN);
  assign rd_len_o = len_tbl[rd_page_i];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hs_prev      <= 1'b1;
      vs_prev      <= 1'b1;
      pcnt         <= '0;
      wr_en_o      <= 1'b0;
      wr_page_o    <= '0;
      line_start_o <= 1'b0;
      frame_tgl_o  <= 1'b0;
      line_ok_o    <= 1'b0;
      for (int i = 0; i < BUF_PAGES; i++) len_tbl[i] <= '0;
    end else begin
      line_start_o <= hs_fall;
      wr_en_o      <= pix_valid_i && in_win;
      if (pix_valid_i) begin
        hs_prev <= hsync_n_i;
        vs_prev <= vsync_n_i;
        pcnt    <= p_cur;
        if (p_cur == PCNT_MAX) line_ok_o <= 1'b0;  // runaway line
        if (hs_fall) begin
          len_tbl[wr_page_o] <= pcnt + 1'b1;         // finished line length
          line_ok_o          <= 1'b1;
          wr_page_o <= (wr_page_o == PAGE_W'(BUF_PAGES - 1)) ? '0 : wr_page_o + 1'b1;
        end
        if (vs_fall) begin
          frame_tgl_o <= ~frame_tgl_o;
          wr_page_o   <= '0;                         // frame restarts on page 0
        end
      end
    end
  end

  // pixel payload, written one cycle after the sample
  always_ff @(posedge clk_i) begin
    wr_addr_o <= ADDR_W'(p_cur - ACTIVE_START);
    wr_data_o <= {red_i, green_i, blue_i};
  end

  a_wr_addr_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_en_o |-> wr_addr_o < ACTIVE_LEN);

endmodule

//--- source/line_buffer.sv
// paged line buffer
`timescale 1ns/1ns

module line_buffer (
  input  logic                               clk_i,
  input  logic                               wr_en_i,
  input  logic [linemult_pkg::PAGE_W-1:0]    wr_page_i,
  input  logic [linemult_pkg::ADDR_W-1:0]    wr_addr_i,
  input  logic [3*linemult_pkg::COLOR_W-1:0] wr_data_i,
  input  logic [linemult_pkg::PAGE_W-1:0]    rd_page_i,
  input  logic [linemult_pkg::ADDR_W-1:0]    rd_addr_i,
  output logic [3*linemult_pkg::COLOR_W-1:0] rd_data_o
);

  import linemult_pkg::*;

  localparam int DEPTH = BUF_PAGES * (2 ** ADDR_W);

  logic [3*COLOR_W-1:0] mem [DEPTH];

  // page selects the upper address bits
  always_ff @(posedge clk_i) begin
    if (wr_en_i) mem[{wr_page_i, wr_addr_i}] <= wr_data_i;
    rd_data_o <= mem[{rd_page_i, rd_addr_i}];  // one cycle read latency
  end

endmodule

//--- source/line_reader.sv
// doubled line reader
`timescale 1ns/1ns

module line_reader #(
  parameter int ACTIVE_START = linemult_pkg::DEF_ACTIVE_START,
  parameter int ACTIVE_LEN   = linemult_pkg::DEF_ACTIVE_LEN
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            enable_i,
  input  logic                            line_start_i,
  input  logic                            frame_tgl_i,
  input  logic                            line_ok_i,
  input  logic [linemult_pkg::PAGE_W-1:0] wr_page_i,
  input  logic [linemult_pkg::HCNT_W-1:0] line_len_i,
  output logic [linemult_pkg::PAGE_W-1:0] rd_page_o,
  output logic [linemult_pkg::ADDR_W-1:0] rd_addr_o,
  output logic                            hsync_n_o,
  output logic                            vsync_n_o,
  output logic                            active_o,
  output logic                            rep_odd_o,
  output logic                            reading_o
);

  import linemult_pkg::*;

  localparam int VCNT_W = $clog2(VS_LINES + 1);

  rd_state_e         state;
  logic [HCNT_W-1:0] h;           // output hcount
  logic              rep;         // repeat index of the current page
  logic [VCNT_W-1:0] vcnt;        // output lines since frame start, saturating
  logic              frame_seen;  // last frame toggle taken
  logic              reading, h_last, in_win;

  assign reading   = (state == ST_READING);
  assign h_last    = ({1'b0, h} + 1'b1) >= {1'b0, line_len_i};
  assign in_win    = reading && (h >= ACTIVE_START) && (h < ACTIVE_START + ACTIVE_LEN);
  assign rd_addr_o = in_win ? ADDR_W'(h - ACTIVE_START) : '0;

  //////////////////////////////
  // read FSM and counters
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state      <= ST_WAIT_FRAME;
      h          <= '0;
      rep        <= 1'b0;
      rd_page_o  <= '0;
      vcnt       <= VCNT_W'(VS_LINES);
      frame_seen <= 1'b0;
    end else if (!enable_i || !line_ok_i) begin
      state      <= ST_WAIT_FRAME;
      frame_seen <= frame_tgl_i;  // drop stale frame starts
    end else begin
      case (state)
        ST_WAIT_FRAME:
          if (frame_tgl_i != frame_seen) begin
            frame_seen <= frame_tgl_i;
            state      <= ST_RD_READY;
          end
        ST_RD_READY:
          if (line_start_i) begin
            state     <= ST_READING;
            h         <= '0;
            rep       <= 1'b0;
            vcnt      <= '0;
            rd_page_o <= PAGE_W'((int'(wr_page_i) + BUF_PAGES - 2) % BUF_PAGES);  // two behind
          end
        ST_READING:
          if (h_last) begin
            h   <= '0;
            rep <= ~rep;
            if (rep) rd_page_o <= PAGE_W'((int'(rd_page_o) + 1) % BUF_PAGES);
            if (frame_tgl_i != frame_seen) begin
              frame_seen <= frame_tgl_i;
              vcnt       <= '0;
            end else if (vcnt != VCNT_W'(VS_LINES)) begin
              vcnt <= vcnt + 1'b1;
            end
          end else begin
            h <= h + 1'b1;
          end
        default: state <= ST_WAIT_FRAME;
      endcase
    end
  end

  // sync and flags, registered to line up with buffer read data
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hsync_n_o <= 1'b1;
      vsync_n_o <= 1'b1;
      active_o  <= 1'b0;
      rep_odd_o <= 1'b0;
      reading_o <= 1'b0;
    end else begin
      hsync_n_o <= !(reading && h < HS_WIDTH);
      vsync_n_o <= !(reading && vcnt < VS_LINES);
      active_o  <= in_win;
      rep_odd_o <= rep;
      reading_o <= reading;
    end
  end

  a_page_apart: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    reading |-> rd_page_o != wr_page_i);

endmodule

//--- source/scanline_blend.sv
// scanline and output select
`timescale 1ns/1ns

module scanline_blend (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               enable_i,
  input  logic                               sl_en_i,
  input  logic [7:0]                         sl_str_i,
  input  logic [3*linemult_pkg::COLOR_W-1:0] pix_i,
  input  logic                               hsync_n_i,
  input  logic                               vsync_n_i,
  input  logic                               active_i,
  input  logic                               rep_odd_i,
  input  logic                               reading_i,
  input  logic                               pass_valid_i,
  input  logic                               pass_hsync_n_i,
  input  logic                               pass_vsync_n_i,
  input  logic [3*linemult_pkg::COLOR_W-1:0] pass_pix_i,
  output logic                               valid_o,
  output logic                               hsync_n_o,
  output logic                               vsync_n_o,
  output logic [linemult_pkg::COLOR_W-1:0]   red_o,
  output logic [linemult_pkg::COLOR_W-1:0]   green_o,
  output logic [linemult_pkg::COLOR_W-1:0]   blue_o
);

  import linemult_pkg::*;

  localparam int PIX_W = 3 * COLOR_W;
  localparam int PD    = PASS_LAT - 1;  // bypass stages before the output register

  logic [PIX_W-1:0] pix_s1, dim_pix;
  logic             dark_s1, hs_s1, vs_s1, val_s1;
  logic [7:0]       gain;
  logic [PD-1:0]    pass_val_d, pass_hs_d, pass_vs_d;
  logic [PIX_W-1:0] pass_pix_d [PD];

  // c * (255 - strength) >> 8 per channel
  always_comb begin
    for (int ch = 0; ch < 3; ch++) begin
      dim_pix[ch*COLOR_W +: COLOR_W] = COLOR_W'((16'(pix_s1[ch*COLOR_W +: COLOR_W]) * gain) >> 8);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      {dark_s1, val_s1} <= 2'b00;
      {hs_s1, vs_s1}    <= 2'b11;
      gain              <= 8'd255;
      pass_val_d        <= '0;
      pass_hs_d         <= '1;
      pass_vs_d         <= '1;
      valid_o           <= 1'b0;
      hsync_n_o         <= 1'b1;
      vsync_n_o         <= 1'b1;
    end else begin
      dark_s1 <= sl_en_i && rep_odd_i;  // darken the second line of each pair
      val_s1  <= reading_i;
      hs_s1   <= hsync_n_i;
      vs_s1   <= vsync_n_i;
      gain    <= 8'd255 - sl_str_i;
      pass_val_d[0] <= pass_valid_i;
      pass_hs_d[0]  <= pass_hsync_n_i;
      pass_vs_d[0]  <= pass_vsync_n_i;
      for (int i = 1; i < PD; i++) begin
        pass_val_d[i] <= pass_val_d[i-1];
        pass_hs_d[i]  <= pass_hs_d[i-1];
        pass_vs_d[i]  <= pass_vs_d[i-1];
      end
      valid_o   <= enable_i ? val_s1 : pass_val_d[PD-1];
      hsync_n_o <= enable_i ? hs_s1  : pass_hs_d[PD-1];
      vsync_n_o <= enable_i ? vs_s1  : pass_vs_d[PD-1];
    end
  end

  // colour payload
  always_ff @(posedge clk_i) begin
    pix_s1        <= active_i ? pix_i : '0;  // blank outside the window
    pass_pix_d[0] <= pass_pix_i;
    for (int i = 1; i < PD; i++) pass_pix_d[i] <= pass_pix_d[i-1];
    if (!enable_i) {red_o, green_o, blue_o} <= pass_pix_d[PD-1];
    else if (dark_s1) {red_o, green_o, blue_o} <= dim_pix;
    else {red_o, green_o, blue_o} <= pix_s1;
  end

endmodule

//--- source/linemult_top.sv
// line doubler top level
`timescale 1ns/1ns

module linemult_top #(
  parameter int ACTIVE_START = linemult_pkg::DEF_ACTIVE_START,
  parameter int ACTIVE_LEN   = linemult_pkg::DEF_ACTIVE_LEN
) (
  input  logic                             VCLK_o,
  input  logic                             nVRST_o,
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [7:0]                       paddr_i,
  input  logic [31:0]                      pwdata_i,
  output logic [31:0]                      prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,
  input  logic                             pix_valid_i,
  input  logic                             hsync_n_i,
  input  logic                             vsync_n_i,
  input  logic [linemult_pkg::COLOR_W-1:0] red_i,
  input  logic [linemult_pkg::COLOR_W-1:0] green_i,
  input  logic [linemult_pkg::COLOR_W-1:0] blue_i,
  output logic                             valid_o,
  output logic                             hsync_n_o,
  output logic                             vsync_n_o,
  output logic [linemult_pkg::COLOR_W-1:0] red_o,
  output logic [linemult_pkg::COLOR_W-1:0] green_o,
  output logic [linemult_pkg::COLOR_W-1:0] blue_o
);

  import linemult_pkg::*;

  logic                 enable, sl_en;
  logic [7:0]           sl_str;
  logic                 wr_en, line_start, frame_tgl, line_ok;
  logic [PAGE_W-1:0]    wr_page, rd_page;
  logic [ADDR_W-1:0]    wr_addr, rd_addr;
  logic [3*COLOR_W-1:0] wr_data, rd_data;
  logic [HCNT_W-1:0]    rd_len;
  logic                 rd_hs_n, rd_vs_n, rd_active, rd_rep_odd, rd_reading;

  linemult_cfg_apb cfg_i (
    .clk_i(VCLK_o), .rst_n_i(nVRST_o),
    .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .enable_o(enable), .sl_en_o(sl_en), .sl_str_o(sl_str)
  );

  line_writer #(.ACTIVE_START(ACTIVE_START), .ACTIVE_LEN(ACTIVE_LEN)) writer_i (
    .clk_i(VCLK_o), .rst_n_i(nVRST_o),
    .pix_valid_i, .hsync_n_i, .vsync_n_i, .red_i, .green_i, .blue_i,
    .rd_page_i(rd_page),
    .wr_en_o(wr_en), .wr_page_o(wr_page), .wr_addr_o(wr_addr), .wr_data_o(wr_data),
    .line_start_o(line_start), .frame_tgl_o(frame_tgl), .line_ok_o(line_ok),
    .rd_len_o(rd_len)
  );

  line_buffer buf_i (
    .clk_i(VCLK_o),
    .wr_en_i(wr_en), .wr_page_i(wr_page), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
    .rd_page_i(rd_page), .rd_addr_i(rd_addr), .rd_data_o(rd_data)
  );

  line_reader #(.ACTIVE_START(ACTIVE_START), .ACTIVE_LEN(ACTIVE_LEN)) reader_i (
    .clk_i(VCLK_o), .rst_n_i(nVRST_o),
    .enable_i(enable), .line_start_i(line_start), .frame_tgl_i(frame_tgl),
    .line_ok_i(line_ok), .wr_page_i(wr_page), .line_len_i(rd_len),
    .rd_page_o(rd_page), .rd_addr_o(rd_addr),
    .hsync_n_o(rd_hs_n), .vsync_n_o(rd_vs_n), .active_o(rd_active),
    .rep_odd_o(rd_rep_odd), .reading_o(rd_reading)
  );

  scanline_blend blend_i (
    .clk_i(VCLK_o), .rst_n_i(nVRST_o),
    .enable_i(enable), .sl_en_i(sl_en), .sl_str_i(sl_str),
    .pix_i(rd_data), .hsync_n_i(rd_hs_n), .vsync_n_i(rd_vs_n),
    .active_i(rd_active), .rep_odd_i(rd_rep_odd), .reading_i(rd_reading),
    .pass_valid_i(pix_valid_i), .pass_hsync_n_i(hsync_n_i), .pass_vsync_n_i(vsync_n_i),
    .pass_pix_i({red_i, green_i, blue_i}),
    .valid_o, .hsync_n_o, .vsync_n_o, .red_o, .green_o, .blue_o
  );

endmodule

//--- tests/linemult_checks.sv
// line doubler checker
`timescale 1ns/1ns

module linemult_checks #(
  parameter int ACTIVE_START = 8,
  parameter int ACTIVE_LEN   = 32,
  parameter int LINE_LEN     = 60
) (
  input  logic        VCLK_o, nVRST_o, idle_i,
  input  logic        psel_i, penable_i, pwrite_i,
  input  logic [7:0]  paddr_i,
  input  logic [31:0] pwdata_i, prdata_o,
  input  logic        pready_o, pslverr_o,
  input  logic        pix_valid_i, hsync_n_i, vsync_n_i,
  input  logic [6:0]  red_i, green_i, blue_i,
  input  logic        valid_o, hsync_n_o, vsync_n_o,
  input  logic [6:0]  red_o, green_o, blue_o,
  output int          value_err_o,
  output int          other_err_o
);

  logic [1:0]  sh_ctrl;                        // expected enable and scanline enable
  logic [7:0]  sh_str;
  logic        map_ok, apb_acc, out_fall, in_fall, locked, armed, second, chk;
  logic [31:0] rd_exp;
  logic [23:0] in_d [3];                       // input history for bypass
  logic [23:0] out_vec;
  logic [6:0]  pair_red, base_g, exp_green, exp_red;
  logic        hs_o_prev, hs_i_prev;
  int          byp_age, settle, since_hs, h_pos, out_falls;
  int          value_errs = 0;
  int          other_errs = 0;

  // plan rule for a darkened channel
  function automatic logic [6:0] dim(logic [6:0] c, logic [7:0] s);
    return 7'((16'(c) * 16'(8'd255 - s)) >> 8);
  endfunction

  task automatic value_error(string name, int got, int exp);
    value_errs++;
    $display("error %0t %s got %0d expected %0d", $time, name, got, exp);
  endtask

  task automatic other_error(string what);
    other_errs++;
    $display("%0t %s", $time, what);
  endtask

  assign value_err_o = value_errs;
  assign other_err_o = other_errs;
  assign map_ok   = (paddr_i == 8'h00) || (paddr_i == 8'h04);
  assign apb_acc  = psel_i && penable_i;
  assign rd_exp   = (paddr_i == 8'h00) ? {30'd0, sh_ctrl} : {24'd0, sh_str};
  assign out_vec  = {valid_o, hsync_n_o, vsync_n_o, red_o, green_o, blue_o};
  assign out_fall = hs_o_prev && !hsync_n_o;
  assign in_fall  = pix_valid_i && hs_i_prev && !hsync_n_i;
  assign h_pos    = out_fall ? 0 : since_hs + 1;  // position in the output line
  assign chk      = locked && settle >= 4;
  assign base_g   = (h_pos >= ACTIVE_START && h_pos < ACTIVE_START + ACTIVE_LEN) ?
                    7'(h_pos) : 7'd0;
  assign exp_green = (sh_ctrl[1] && second) ? dim(base_g, sh_str) : base_g;
  assign exp_red   = (sh_ctrl[1] && second) ? dim(pair_red, sh_str) : pair_red;

  always_ff @(posedge VCLK_o) begin
    in_d[0] <= {pix_valid_i, hsync_n_i, vsync_n_i, red_i, green_i, blue_i};
    in_d[1] <= in_d[0];
    in_d[2] <= in_d[1];
  end

  //////////////////////////////
  // reference state
  //////////////////////////////
  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      sh_ctrl  <= '0;
      sh_str   <= '0;
      {byp_age, settle, since_hs, out_falls} <= '0;
      {hs_o_prev, hs_i_prev} <= 2'b11;
      {locked, armed, second} <= 3'b000;
      pair_red <= '0;
    end else begin
      if (apb_acc && pwrite_i && map_ok) begin
        if (paddr_i == 8'h00) sh_ctrl <= pwdata_i[1:0];
        else sh_str <= pwdata_i[7:0];
      end
      settle    <= (apb_acc && pwrite_i) ? 0 : (settle < 7 ? settle + 1 : settle);
      byp_age   <= sh_ctrl[0] ? 0 : (byp_age < 3 ? byp_age + 1 : byp_age);
      hs_o_prev <= hsync_n_o;
      since_hs  <= h_pos;
      if (pix_valid_i) hs_i_prev <= hsync_n_i;
      if (!sh_ctrl[0]) locked <= 1'b0;
      else if (out_fall && settle >= 4) locked <= 1'b1;  // first doubled line
      if (out_fall) second <= locked ? !second : 1'b0;
      if (h_pos == ACTIVE_START && !second) pair_red <= red_o;
      if (in_fall) begin
        out_falls <= out_fall ? 1 : 0;
        armed     <= locked;
      end else if (out_fall) begin
        out_falls <= out_falls + 1;
      end
      if (!locked) armed <= 1'b0;
    end
  end

  a_idle: assert property (@(posedge VCLK_o)
    (!nVRST_o || idle_i) |-> !valid_o && hsync_n_o && vsync_n_o)
    else other_error("outputs not idle during reset or before the first input");
  a_pready: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
    apb_acc |-> pready_o) else other_error("PREADY low in an access phase");
  a_pslverr: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
    apb_acc |-> pslverr_o == !map_ok) else other_error("PSLVERR wrong for the address");
  a_rdata: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
    apb_acc && !pwrite_i && map_ok |-> prdata_o == rd_exp)
    else value_error("prdata_o", int'(prdata_o), int'(rd_exp));
  a_bypass: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
    byp_age >= 3 && !sh_ctrl[0] |-> out_vec == in_d[2])
    else value_error("bypass outputs", int'(out_vec), int'(in_d[2]));
  a_period: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
    locked && out_fall |-> since_hs == LINE_LEN - 1)
    else value_error("hsync_n_o period", since_hs + 1, LINE_LEN);
  a_two_lines: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
    armed && in_fall |-> out_falls == 2)
    else value_error("hsync_n_o falls per input line", out_falls, 2);
  a_valid: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
    chk |-> valid_o) else other_error("valid_o dropped while doubling");
  a_green: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
    chk |-> green_o == exp_green)
    else value_error("green_o", int'(green_o), int'(exp_green));
  a_red: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
    chk && second && h_pos == ACTIVE_START |-> red_o == exp_red)
    else value_error("red_o", int'(red_o), int'(exp_red));

endmodule

//--- tests/linemult_tb.sv
// line doubler testbench
`timescale 1ns/1ns

module linemult_tb;

  localparam int ACTIVE_START = 8;
  localparam int ACTIVE_LEN   = 32;
  localparam int LINE_PIX     = 60;                 // pixels per input line
  localparam int FRAME_LINES  = 12;
  localparam int FRAME_CYC    = FRAME_LINES * 2 * LINE_PIX;
  // one bypass frame, up to two to lock, four doubled frames
  localparam int MAX_CYCLES   = 7 * FRAME_CYC + 400;

  logic        VCLK_o, nVRST_o, idle_i;
  logic        psel_i, penable_i, pwrite_i;
  logic [7:0]  paddr_i;
  logic [31:0] pwdata_i, prdata_o;
  logic        pready_o, pslverr_o;
  logic        pix_valid_i, hsync_n_i, vsync_n_i;
  logic [6:0]  red_i, green_i, blue_i;
  logic        valid_o, hsync_n_o, vsync_n_o;
  logic [6:0]  red_o, green_o, blue_o;
  int          value_err_o, other_err_o;
  int          seed;
  int          cycles = 0;

  linemult_top #(.ACTIVE_START(ACTIVE_START), .ACTIVE_LEN(ACTIVE_LEN)) dut_i (.*);

  linemult_checks #(
    .ACTIVE_START(ACTIVE_START), .ACTIVE_LEN(ACTIVE_LEN), .LINE_LEN(LINE_PIX)
  ) chk_i (.*);

  initial begin
    VCLK_o = 1'b0;
    forever #4 VCLK_o = ~VCLK_o;
  end

  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data);
    @(negedge VCLK_o);
    psel_i   = 1'b1;                                // setup phase
    pwrite_i = wr;
    paddr_i  = addr;
    pwdata_i = data;
    @(negedge VCLK_o);
    penable_i = 1'b1;
    @(negedge VCLK_o);
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  // one sample every second cycle, hsync low for pixels 0..3
  task automatic drive_video();
    forever begin
      for (int ln = 0; ln < FRAME_LINES; ln++) begin
        for (int p = 0; p < LINE_PIX; p++) begin
          @(negedge VCLK_o);
          pix_valid_i = 1'b1;
          hsync_n_i   = (p >= 4);
          vsync_n_i   = (ln != 0);
          red_i       = 7'(ln);
          green_i     = 7'(p);
          blue_i      = 7'($random(seed));
          @(negedge VCLK_o);
          pix_valid_i = 1'b0;
        end
      end
    end
  endtask

  always @(posedge VCLK_o) begin
    cycles <= cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("timeout after %0d cycles, the run did not complete", cycles);
      $display("test failed");
      $finish;
    end
  end

  initial begin
    seed = 80;
    {nVRST_o, idle_i} = 2'b10;
    {psel_i, penable_i, pwrite_i} = 3'b000;
    paddr_i  = '0;
    pwdata_i = '0;
    {pix_valid_i, hsync_n_i, vsync_n_i} = 3'b011;
    {red_i, green_i, blue_i} = '0;
    @(negedge VCLK_o);
    {nVRST_o, idle_i} = 2'b01;                     // reset falls on the first falling edge
    repeat (10) @(posedge VCLK_o);
    @(negedge VCLK_o);
    nVRST_o = 1'b1;

    //////////////////////////////
    // register access
    //////////////////////////////
    apb_xfer(1'b1, 8'h00, 32'h2);
    apb_xfer(1'b0, 8'h00, 32'h0);
    apb_xfer(1'b1, 8'h00, 32'h0);
    apb_xfer(1'b1, 8'h04, 32'ha5);
    apb_xfer(1'b0, 8'h04, 32'h0);
    apb_xfer(1'b1, 8'h08, 32'hff);                 // unmapped, no effect
    apb_xfer(1'b0, 8'h08, 32'h0);
    apb_xfer(1'b0, 8'h04, 32'h0);
    apb_xfer(1'b0, 8'h00, 32'h0);
    apb_xfer(1'b1, 8'h04, 32'h40);                 // strength for the scanline pass

    // bypass for one frame, then doubling
    idle_i = 1'b0;
    fork
      drive_video();
    join_none
    repeat (FRAME_CYC) @(posedge VCLK_o);
    apb_xfer(1'b1, 8'h00, 32'h1);
    repeat (8) @(posedge VCLK_o);
    @(negedge hsync_n_o);                           // reader has locked
    repeat (2 * FRAME_CYC) @(posedge VCLK_o);
    apb_xfer(1'b1, 8'h00, 32'h3);
    repeat (2 * FRAME_CYC) @(posedge VCLK_o);

    $display("errors: value %0d, other %0d", value_err_o, other_err_o);
    if (value_err_o == 0 && other_err_o == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

//--- linemult_top.f
source/linemult_pkg.sv
source/linemult_cfg_apb.sv
source/line_writer.sv
source/line_buffer.sv
source/line_reader.sv
source/scanline_blend.sv
source/linemult_top.sv
tests/linemult_checks.sv
tests/linemult_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the line doubler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module linemult_tb \
  -f linemult_top.f -o linemult_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/linemult_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1
